//--- design/iq_pkg.sv
`default_nettype none

package iq_pkg;

	// front end geometry
	// the top level takes these as parameter defaults and may override them
	localparam int FETCH_WIDTH = 4;   // words per fetch block, power of two
	localparam int IQ_DEPTH    = 8;   // entries per lane, power of two
	localparam int XLEN        = 32;  // program counter width

	// one fixed-size instruction word
	typedef logic [31:0] instr_t;

	// program counter
	typedef logic [XLEN-1:0] pc_t;

	// one queued instruction
	// the same layout goes out to decode unchanged
	typedef struct packed {
		pc_t    pc;          // address of this word
		instr_t instr;       // raw encoding
		logic   pred_taken;  // predictor said taken here, block ends on it
	} iq_entry_t;

endpackage

`default_nettype wire

//--- design/lane_fifo.sv
`default_nettype none

// one lane of the instruction queue
// circular buffer, head entry always visible on data_o
module lane_fifo #(
	parameter int unsigned DEPTH = 8,             // power of two, at least 2
	parameter type         dtype = logic [31:0]
) (
	input  logic clk,
	input  logic rst_n,
	input  logic flush_i,
	input  logic push_i,
	input  logic pop_i,
	input  dtype data_i,
	output dtype data_o,
	output logic full_o,
	output logic empty_o
);

	typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

	dtype mem [DEPTH];
	ptr_t rd_ptr;
	ptr_t wr_ptr;
	cnt_t count;
	logic do_push;
	logic do_pop;

	assign full_o  = (count == cnt_t'(DEPTH));
	assign empty_o = (count == '0);

	// requests that cannot be served are dropped
	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & ~empty_o;

	assign data_o = mem[rd_ptr];  // head of lane

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else if (flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + ptr_t'(1);  // wraps, depth is a power of two
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + ptr_t'(1);
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + cnt_t'(1);
				2'b01:   count <= count - cnt_t'(1);
				default: count <= count;  // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= data_i;
		end
	end

endmodule

`default_nettype wire

//--- design/multi_queue.sv
`default_nettype none

// rotating multi-lane queue
// word n of the stream sits in lane (n mod CHANNEL), so up to CHANNEL
// words go in and come out per cycle while program order is kept
module multi_queue #(
	parameter int unsigned CHANNEL = 4,             // lane count, power of two, at least 2
	parameter int unsigned DEPTH   = 8,             // entries per lane, power of two
	parameter type         dtype   = logic [31:0]
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         flush_i,
	input  logic                         stall_push_i,
	output logic                         full_o,        // any lane full
	output logic                         empty_o,       // every lane empty

	input  dtype [CHANNEL-1:0]           data_push_i,   // block order, not lane order
	input  logic [$clog2(CHANNEL+1)-1:0] push_num_i,
	input  logic [$clog2(CHANNEL)-1:0]   push_offset_i, // first block slot to take

	output dtype [CHANNEL-1:0]           data_pop_o,    // index 0 is the oldest
	output logic [CHANNEL-1:0]           pop_valid_o,
	input  logic [$clog2(CHANNEL+1)-1:0] pop_num_i
);

	typedef logic [$clog2(CHANNEL)-1:0] lane_t;

	lane_t rd_ptr;  // lane holding the oldest word
	lane_t wr_ptr;  // lane that takes the next pushed word

	logic [CHANNEL-1:0] lane_push;
	logic [CHANNEL-1:0] lane_pop;
	logic [CHANNEL-1:0] lane_full;
	logic [CHANNEL-1:0] lane_empty;
	dtype [CHANNEL-1:0] lane_din;
	dtype [CHANNEL-1:0] lane_dout;

	lane_t [CHANNEL-1:0] rd_lane;   // program slot i -> physical lane
	lane_t [CHANNEL-1:0] rd_slot;   // physical lane -> distance from read pointer
	lane_t [CHANNEL-1:0] wr_slot;   // physical lane -> distance from write pointer
	lane_t [CHANNEL-1:0] src_idx;   // block slot feeding each lane

	assign full_o  = |lane_full;
	assign empty_o = &lane_empty;

	for (genvar i = 0; i < CHANNEL; i++) begin : gen_index
		assign rd_lane[i] = rd_ptr + lane_t'(i);
		assign rd_slot[i] = lane_t'(i) - rd_ptr;
		assign wr_slot[i] = lane_t'(i) - wr_ptr;
		assign src_idx[i] = push_offset_i + wr_slot[i];  // wraps mod CHANNEL
	end

	// output side, rotate lane heads back into program order
	for (genvar i = 0; i < CHANNEL; i++) begin : gen_pop_side
		assign data_pop_o[i]  = lane_dout[rd_lane[i]];
		assign pop_valid_o[i] = ~lane_empty[rd_lane[i]];
	end

	// input side, the first pushed word lands in the write pointer lane
	for (genvar i = 0; i < CHANNEL; i++) begin : gen_push_side
		assign lane_din[i]  = data_push_i[src_idx[i]];
		assign lane_push[i] = ~stall_push_i & (wr_slot[i] < push_num_i);
		assign lane_pop[i]  = (rd_slot[i] < pop_num_i);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else if (flush_i) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
		end else begin
			rd_ptr <= rd_ptr + lane_t'(pop_num_i);  // a full count wraps to the same lane
			if (!stall_push_i) begin
				wr_ptr <= wr_ptr + lane_t'(push_num_i);
			end
		end
	end

	for (genvar i = 0; i < CHANNEL; i++) begin : gen_lane
		lane_fifo #(
			.DEPTH   ( DEPTH ),
			.dtype   ( dtype )
		) u_lane (
			.clk     ( clk           ),
			.rst_n   ( rst_n         ),
			.flush_i ( flush_i       ),
			.push_i  ( lane_push[i]  ),
			.pop_i   ( lane_pop[i]   ),
			.data_i  ( lane_din[i]   ),
			.data_o  ( lane_dout[i]  ),
			.full_o  ( lane_full[i]  ),
			.empty_o ( lane_empty[i] )
		);
	end

endmodule

`default_nettype wire

//--- design/fetch_aligner.sv
`default_nettype none

// picks the predicted-path part of an aligned fetch block
// path runs from the pc word up to and including the first taken lane
module fetch_aligner #(
	parameter int unsigned FETCH_WIDTH = 4  // power of two, at least 2
) (
	input  iq_pkg::pc_t                          fetch_pc_i,
	input  iq_pkg::instr_t    [FETCH_WIDTH-1:0]  fetch_instr_i,
	input  logic              [FETCH_WIDTH-1:0]  fetch_taken_i,
	output iq_pkg::iq_entry_t [FETCH_WIDTH-1:0]  entries_o,      // block position
	output logic [$clog2(FETCH_WIDTH)-1:0]       push_offset_o,
	output logic [$clog2(FETCH_WIDTH+1)-1:0]     push_num_o
);

	localparam int unsigned OFF_W = $clog2(FETCH_WIDTH);
	localparam int unsigned BLK_W = OFF_W + 2;  // byte bits inside one block

	typedef logic [$clog2(FETCH_WIDTH+1)-1:0] count_t;

	iq_pkg::pc_t base_pc;
	count_t      path_cnt;
	logic        taken_seen;

	// word index of the pc inside the block
	assign push_offset_o = fetch_pc_i[BLK_W-1:2];

	assign base_pc = {fetch_pc_i[iq_pkg::XLEN-1:BLK_W], {BLK_W{1'b0}}};

	// every lane gets its own pc, only the pushed ones matter
	for (genvar k = 0; k < FETCH_WIDTH; k++) begin : gen_entry
		assign entries_o[k].pc         = base_pc + iq_pkg::pc_t'(k * 4);
		assign entries_o[k].instr      = fetch_instr_i[k];
		assign entries_o[k].pred_taken = fetch_taken_i[k];
	end

	// walk from the offset until the first taken lane
	always_comb begin
		path_cnt   = '0;
		taken_seen = 1'b0;
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			if ((k >= int'(push_offset_o)) && !taken_seen) begin
				path_cnt   = path_cnt + count_t'(1);
				taken_seen = fetch_taken_i[k];  // last word of the path
			end
		end
	end

	assign push_num_o = path_cnt;

endmodule

`default_nettype wire

//--- design/issue_select.sv
`default_nettype none

// hands the oldest ready words to decode
// count is the leading run of valid slots, capped by decode capacity
module issue_select #(
	parameter int unsigned FETCH_WIDTH = 4
) (
	input  logic              [FETCH_WIDTH-1:0]  pop_valid_i,    // index 0 oldest
	input  iq_pkg::iq_entry_t [FETCH_WIDTH-1:0]  pop_entries_i,
	input  logic [$clog2(FETCH_WIDTH+1)-1:0]     decode_ready_i, // words decode can take
	input  logic                                 flush_i,
	output logic [$clog2(FETCH_WIDTH+1)-1:0]     pop_num_o,
	output iq_pkg::iq_entry_t [FETCH_WIDTH-1:0]  issue_entries_o,
	output logic              [FETCH_WIDTH-1:0]  issue_valid_o
);

	typedef logic [$clog2(FETCH_WIDTH+1)-1:0] count_t;

	count_t lead_cnt;
	count_t capped_cnt;
	logic   gap_seen;

	// stop counting at the first hole
	always_comb begin
		lead_cnt = '0;
		gap_seen = 1'b0;
		for (int k = 0; k < FETCH_WIDTH; k++) begin
			if (!pop_valid_i[k]) begin
				gap_seen = 1'b1;
			end else if (!gap_seen) begin
				lead_cnt = lead_cnt + count_t'(1);
			end
		end
	end

	assign capped_cnt = (lead_cnt < decode_ready_i) ? lead_cnt : decode_ready_i;

	// redirect in flight, nothing goes to decode
	assign pop_num_o = flush_i ? '0 : capped_cnt;

	// count to thermometer mask
	for (genvar k = 0; k < FETCH_WIDTH; k++) begin : gen_mask
		assign issue_valid_o[k] = (count_t'(k) < pop_num_o);
	end

	assign issue_entries_o = pop_entries_i;

endmodule

`default_nettype wire

//--- design/instr_buffer_top.sv
`default_nettype none

// instruction buffer between fetch and decode
module instr_buffer_top #(
	parameter int unsigned FETCH_WIDTH = iq_pkg::FETCH_WIDTH,
	parameter int unsigned IQ_DEPTH    = iq_pkg::IQ_DEPTH
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 flush_i,         // branch redirect

	input  logic                                 fetch_valid_i,
	output logic                                 fetch_ready_o,
	input  iq_pkg::pc_t                          fetch_pc_i,
	input  iq_pkg::instr_t    [FETCH_WIDTH-1:0]  fetch_instr_i,
	input  logic              [FETCH_WIDTH-1:0]  fetch_taken_i,

	input  logic [$clog2(FETCH_WIDTH+1)-1:0]     decode_ready_i,
	output iq_pkg::iq_entry_t [FETCH_WIDTH-1:0]  issue_entries_o,
	output logic              [FETCH_WIDTH-1:0]  issue_valid_o
);

	iq_pkg::iq_entry_t [FETCH_WIDTH-1:0] push_entries;
	iq_pkg::iq_entry_t [FETCH_WIDTH-1:0] pop_entries;
	logic [$clog2(FETCH_WIDTH)-1:0]      push_offset;
	logic [$clog2(FETCH_WIDTH+1)-1:0]    push_num;
	logic [$clog2(FETCH_WIDTH+1)-1:0]    pop_num;
	logic [FETCH_WIDTH-1:0]              pop_valid;
	logic                                queue_full;
	logic                                push_stall;

	// any full lane holds the whole block back
	assign fetch_ready_o = ~queue_full;
	assign push_stall    = flush_i | ~(fetch_valid_i & fetch_ready_o);  // push only on accept

	fetch_aligner #(
		.FETCH_WIDTH    ( FETCH_WIDTH )
	) u_aligner (
		.fetch_pc_i     ( fetch_pc_i    ),
		.fetch_instr_i  ( fetch_instr_i ),
		.fetch_taken_i  ( fetch_taken_i ),
		.entries_o      ( push_entries  ),
		.push_offset_o  ( push_offset   ),
		.push_num_o     ( push_num      )
	);

	multi_queue #(
		.CHANNEL        ( FETCH_WIDTH        ),
		.DEPTH          ( IQ_DEPTH           ),
		.dtype          ( iq_pkg::iq_entry_t )
	) u_queue (
		.clk            ( clk          ),
		.rst_n          ( rst_n        ),
		.flush_i        ( flush_i      ),
		.stall_push_i   ( push_stall   ),
		.full_o         ( queue_full   ),
		.empty_o        (              ),  // pop_valid already says it
		.data_push_i    ( push_entries ),
		.push_num_i     ( push_num     ),
		.push_offset_i  ( push_offset  ),
		.data_pop_o     ( pop_entries  ),
		.pop_valid_o    ( pop_valid    ),
		.pop_num_i      ( pop_num      )
	);

	issue_select #(
		.FETCH_WIDTH     ( FETCH_WIDTH )
	) u_select (
		.pop_valid_i     ( pop_valid       ),
		.pop_entries_i   ( pop_entries     ),
		.decode_ready_i  ( decode_ready_i  ),
		.flush_i         ( flush_i         ),
		.pop_num_o       ( pop_num         ),
		.issue_entries_o ( issue_entries_o ),
		.issue_valid_o   ( issue_valid_o   )
	);

endmodule

`default_nettype wire

//--- test/instr_buffer_assert.sv
`default_nettype none

// protocol checks on the instruction buffer ports
module instr_buffer_assert #(
	parameter int unsigned FETCH_WIDTH = 4
) (
	input logic                             clk,
	input logic                             rst_n,
	input logic                             flush_i,
	input logic                             fetch_valid_i,
	input logic                             fetch_ready_i,
	input iq_pkg::pc_t                      fetch_pc_i,
	input iq_pkg::instr_t [FETCH_WIDTH-1:0] fetch_instr_i,
	input logic [FETCH_WIDTH-1:0]           fetch_taken_i,
	input logic [FETCH_WIDTH-1:0]           issue_valid_i
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [FETCH_WIDTH-1:0] valid_plus_one;

	// low-bit mask plus one has no bit in common with the mask
	assign valid_plus_one = issue_valid_i + 1'b1;

	mask_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
		(issue_valid_i & valid_plus_one) == '0)
		else $error("issue_valid_o %b is not a contiguous low mask", issue_valid_i);

	idle_after_reset: assert property (@(posedge clk)
		$rose(rst_n) |-> issue_valid_i == '0)
		else $error("issue_valid_o %b in the first cycle after reset", issue_valid_i);

	idle_on_flush: assert property (@(posedge clk) disable iff (!rst_n)
		flush_i |-> issue_valid_i == '0)
		else $error("issue_valid_o %b during a flush", issue_valid_i);

	// fetch side must hold a waiting block
	fetch_held: assert property (@(posedge clk) disable iff (!rst_n)
		(fetch_valid_i && !fetch_ready_i && !flush_i) |=>
		(fetch_valid_i && $stable(fetch_pc_i) && $stable(fetch_instr_i)
			&& $stable(fetch_taken_i)))
		else $error("blocked fetch block changed before it was accepted");

endmodule

bind instr_buffer_top instr_buffer_assert #(
	.FETCH_WIDTH   ( FETCH_WIDTH )
) u_assert (
	.clk           ( clk             ),
	.rst_n         ( rst_n           ),
	.flush_i       ( flush_i         ),
	.fetch_valid_i ( fetch_valid_i   ),
	.fetch_ready_i ( fetch_ready_o   ),
	.fetch_pc_i    ( fetch_pc_i      ),
	.fetch_instr_i ( fetch_instr_i   ),
	.fetch_taken_i ( fetch_taken_i   ),
	.issue_valid_i ( issue_valid_o   )
);

`default_nettype wire

//--- test/instr_buffer_tb.sv
`default_nettype none

module instr_buffer_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int FW      = iq_pkg::FETCH_WIDTH;
	localparam int DEPTH   = iq_pkg::IQ_DEPTH;
	localparam int CNT_W   = $clog2(FW + 1);
	localparam int MAX_OPS = 64;
	localparam int FIELDS  = 6;  // test, valid, pc, taken, decode_ready, flush
	localparam logic [15:0] LFSR_SEED = 16'd38514;
	localparam logic [15:0] LFSR_TAPS = 16'hb400;  // x^16 + x^14 + x^13 + x^11 + 1

	logic                       clk;
	logic                       rst_n;
	logic                       flush;
	logic                       fetch_valid;
	logic                       fetch_ready;
	iq_pkg::pc_t                fetch_pc;
	iq_pkg::instr_t [FW-1:0]    fetch_instr;
	logic [FW-1:0]              fetch_taken;
	logic [CNT_W-1:0]           decode_ready;
	iq_pkg::iq_entry_t [FW-1:0] issue_entries;
	logic [FW-1:0]              issue_valid;

	logic [31:0]       op_mem [MAX_OPS*FIELDS];
	iq_pkg::iq_entry_t model_q [$];  // expected words, oldest first
	logic [15:0]       lfsr_state;
	int                n_ops;
	int                cycle_cnt;
	int                cycle_limit;
	int                stall_cycles;
	int                test_checks;
	int                test_errors;
	int                total_checks;
	int                total_errors;
	int                tests_done;

	instr_buffer_top #(
		.FETCH_WIDTH     ( FW    ),
		.IQ_DEPTH        ( DEPTH )
	) DUT (
		.clk             ( clk           ),
		.rst_n           ( rst_n         ),
		.flush_i         ( flush         ),
		.fetch_valid_i   ( fetch_valid   ),
		.fetch_ready_o   ( fetch_ready   ),
		.fetch_pc_i      ( fetch_pc      ),
		.fetch_instr_i   ( fetch_instr   ),
		.fetch_taken_i   ( fetch_taken   ),
		.decode_ready_i  ( decode_ready  ),
		.issue_entries_o ( issue_entries ),
		.issue_valid_o   ( issue_valid   )
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	// one lfsr step per bit of the word
	function automatic iq_pkg::instr_t random_word();
		iq_pkg::instr_t word;
		word = '0;
		for (int b = 0; b < 32; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			word       = {word[30:0], lfsr_state[0]};
		end
		return word;
	endfunction

	task automatic load_ops();
		n_ops = 0;
		$readmemh("test/instr_buffer_input.txt", op_mem);
		// test number ff ends the list
		while (n_ops < MAX_OPS && !$isunknown(op_mem[n_ops*FIELDS])
				&& op_mem[n_ops*FIELDS] != 32'hff) begin
			n_ops++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		test_errors++;
	endtask

	task automatic finish_test(input int num);
		$display("test %0d: %0d checks, %0d errors", num, test_checks, test_errors);
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks  = 0;
		test_errors  = 0;
		tests_done++;
	endtask

	// words on the predicted path: from the pc word up to the first taken lane
	task automatic push_expected();
		iq_pkg::pc_t       base;
		iq_pkg::iq_entry_t entry;
		int                first;
		logic              stop;
		base  = fetch_pc & ~iq_pkg::pc_t'(FW * 4 - 1);
		first = int'((fetch_pc >> 2) % FW);
		stop  = 1'b0;
		for (int k = first; k < FW; k++) begin
			if (!stop) begin
				entry.pc         = base + iq_pkg::pc_t'(4 * k);
				entry.instr      = fetch_instr[k];
				entry.pred_taken = fetch_taken[k];
				model_q.push_back(entry);
				stop = fetch_taken[k];
			end
		end
	endtask

	// called right at a rising edge, outputs still show the old state
	task automatic check_edge(output logic accepted);
		int            n_exp;
		logic [FW-1:0] mask_exp;
		logic          ready_exp;
		// word n sits in lane n mod FW, the fullest lane holds ceil(size / FW)
		ready_exp = (model_q.size() <= FW * (DEPTH - 1));
		n_exp = model_q.size();
		if (n_exp > int'(decode_ready)) begin
			n_exp = int'(decode_ready);
		end
		if (n_exp > FW) begin
			n_exp = FW;
		end
		if (flush) begin
			n_exp = 0;
		end
		mask_exp = '0;
		for (int k = 0; k < n_exp; k++) begin
			mask_exp[k] = 1'b1;
		end
		test_checks++;
		assert (fetch_ready === ready_exp) else begin
			report_error($sformatf("fetch_ready_o is %b, expected %b", fetch_ready, ready_exp));
		end
		test_checks++;
		assert (issue_valid === mask_exp) else begin
			report_error($sformatf("issue_valid_o is %b, expected %b", issue_valid, mask_exp));
		end
		for (int k = 0; k < n_exp; k++) begin
			test_checks++;
			assert (issue_entries[k] === model_q[0]) else begin
				report_error($sformatf(
					"slot %0d pc %h instr %h taken %b, expected pc %h instr %h taken %b",
					k, issue_entries[k].pc, issue_entries[k].instr, issue_entries[k].pred_taken,
					model_q[0].pc, model_q[0].instr, model_q[0].pred_taken));
			end
			void'(model_q.pop_front());
		end
		accepted = fetch_valid && ready_exp && !flush;
		if (flush) begin
			model_q.delete();  // redirect drops everything queued
		end else if (accepted) begin
			push_expected();
		end
		if (fetch_valid && !fetch_ready) begin
			stall_cycles++;
		end
	endtask

	initial begin : run_tests
		int   base;
		int   cur_test;
		logic accepted;
		logic line_done;
		$timeformat(-9, 1, " ns", 0);
		rst_n        = 1'b0;
		flush        = 1'b0;
		fetch_valid  = 1'b0;
		fetch_pc     = '0;
		fetch_instr  = '0;
		fetch_taken  = '0;
		decode_ready = '0;
		lfsr_state   = LFSR_SEED;
		cycle_cnt    = 0;
		cycle_limit  = 0;
		stall_cycles = 0;
		test_checks  = 0;
		test_errors  = 0;
		total_checks = 0;
		total_errors = 0;
		tests_done   = 0;
		load_ops();
		// worst stall is a full queue drained one word per cycle
		cycle_limit = n_ops * (FW * DEPTH + 1) + FW * DEPTH + 60;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		test_checks += 2;
		assert (issue_valid === '0) else begin
			report_error($sformatf("issue_valid_o is %b after reset", issue_valid));
		end
		assert (fetch_ready === 1'b1) else begin
			report_error("fetch_ready_o is low after reset");
		end
		finish_test(0);

		cur_test = -1;
		for (int i = 0; i < n_ops; i++) begin
			base = i * FIELDS;
			if (int'(op_mem[base]) != cur_test) begin
				if (cur_test >= 0) begin
					finish_test(cur_test);
				end
				cur_test = int'(op_mem[base]);
			end
			@(negedge clk);
			fetch_valid  = op_mem[base+1][0];
			fetch_pc     = op_mem[base+2];
			fetch_taken  = op_mem[base+3][FW-1:0];
			decode_ready = op_mem[base+4][CNT_W-1:0];
			flush        = op_mem[base+5][0];
			for (int k = 0; k < FW; k++) begin
				fetch_instr[k] = random_word();
			end
			line_done = 1'b0;
			while (!line_done) begin  // a blocked block is held
				@(posedge clk);
				check_edge(accepted);
				line_done = accepted || !fetch_valid;
			end
		end

		// drain what is left at full decode width
		@(negedge clk);
		fetch_valid  = 1'b0;
		flush        = 1'b0;
		decode_ready = CNT_W'(FW);
		while (model_q.size() > 0) begin
			@(posedge clk);
			check_edge(accepted);
		end
		@(posedge clk);
		check_edge(accepted);  // nothing extra may show up
		if (cur_test >= 0) begin
			finish_test(cur_test);
		end

		total_checks += 2;
		assert (n_ops > 0) else begin
			$display("no operations could be read from test/instr_buffer_input.txt");
			total_errors++;
		end
		assert (stall_cycles > 0) else begin
			$display("fetch_ready_o never dropped, the queue was never filled");
			total_errors++;
		end

		$display("%0d tests, %0d checks, %0d errors", tests_done, total_checks, total_errors);
		if (total_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- test/instr_buffer_input.txt
// test valid pc taken_mask decode_ready flush, all hex
// test ff ends the list
1 1 00001000 0 4 0
1 1 00001010 0 4 0
1 0 00000000 0 4 0
2 1 00002004 0 4 0
2 1 00002010 2 4 0
2 1 0000202c 0 4 0
2 1 00002038 8 4 0
2 1 00002044 1 4 0
2 0 00000000 0 4 0
3 1 00003008 0 1 0
3 1 00003010 4 2 0
3 1 00003024 0 3 0
3 1 00003030 1 1 0
3 1 00003034 0 2 0
3 0 00000000 0 1 0
3 0 00000000 0 2 0
3 0 00000000 0 3 0
4 1 00004000 0 0 0
4 1 00004010 0 1 0
4 0 00000000 0 4 1
4 0 00000000 0 4 0
4 1 00004020 0 4 0
4 0 00000000 0 4 0
5 1 00005000 0 0 0
5 1 00005010 0 0 0
5 1 00005020 0 0 0
5 1 00005030 0 0 0
5 1 00005040 0 0 0
5 1 00005050 0 0 0
5 1 00005060 0 0 0
5 1 00005070 0 0 0
5 1 00005080 0 4 0
ff 0 00000000 0 0 0

//--- verilog.f
design/iq_pkg.sv
design/lane_fifo.sv
design/multi_queue.sv
design/fetch_aligner.sv
design/issue_select.sv
design/instr_buffer_top.sv
test/instr_buffer_assert.sv
test/instr_buffer_tb.sv
